/* src/gsim_decode.sv */
`default_nettype none

module gsim_decode (
	input  logic                i_clk,
	input  logic                i_reset,
	input  logic                i_module_en,
	input  gsim_pkg::mat_cnt_t  i_matrix_num,
	output logic                o_proc_done,
	output logic                o_mem_rreq,
	output gsim_pkg::mem_addr_t o_mem_addr,
	input  logic                i_mem_rrdy,
	input  gsim_pkg::mem_word_t i_mem_dout,
	output gsim_pkg::gsim_op_e  o_op,
	output gsim_pkg::idx_t      o_row,
	output gsim_pkg::idx_t      o_col,
	output gsim_pkg::coef_t     o_coef,
	output gsim_pkg::coef_t     o_rhs,
	output logic                o_last_iter,
	input  logic                i_x_upd
);
	import gsim_pkg::*;

	gsim_state_e state;
	mat_cnt_t    mat_total;
	mat_cnt_t    mat;
	iter_t       iter;
	idx_t        row;
	idx_t        col;
	idx_t        col_nxt;
	mem_word_t   row_buf;
	mem_word_t   b_buf;
	mem_addr_t   mat_base;
	logic        done_q;
	logic        last_row;
	logic        last_iter;
	logic        last_mat;

	assign mat_base  = mem_addr_t'(mat * ROWS_PER_MAT);
	assign last_row  = (row == idx_t'(N_DIM - 1));
	assign last_iter = (iter == iter_t'(ITER_COUNT - 1));
	assign last_mat  = (mat == mat_cnt_t'(mat_total - 1'b1));

	assign o_proc_done = done_q;

	// next column hops over the diagonal and lands on row for the solve
	always_comb begin
		if (col == idx_t'(N_DIM - 1)) begin
			col_nxt = row;
		end else if ((col + 1'b1 == row) && !last_row) begin
			col_nxt = col + 2'd2;
		end else begin
			col_nxt = col + 1'b1;
		end
	end

	always_ff @(posedge i_clk or posedge i_reset) begin
		if (i_reset) begin
			state       <= ST_IDLE;
			mat_total   <= '0;
			mat         <= '0;
			iter        <= '0;
			row         <= '0;
			col         <= '0;
			done_q      <= 1'b0;
			o_mem_rreq  <= 1'b0;
			o_mem_addr  <= '0;
			o_op        <= OP_NOP;
			o_row       <= '0;
			o_col       <= '0;
			o_coef      <= '0;
			o_rhs       <= '0;
			o_last_iter <= 1'b0;
		end else begin
			o_op   <= OP_NOP;
			done_q <= (state == ST_DONE) && i_module_en;
			case (state)
				ST_IDLE: begin
					if (i_module_en) begin
						mat_total <= i_matrix_num;
						mat       <= '0;
						iter      <= '0;
						row       <= '0;
						state     <= ST_FETCH_B;
					end
				end
				ST_FETCH_B: begin
					if (!o_mem_rreq) begin
						o_mem_rreq <= 1'b1;
						o_mem_addr <= mat_base + mem_addr_t'(N_DIM);
					end else if (i_mem_rrdy) begin
						o_mem_rreq <= 1'b0;
						state      <= ST_FETCH_ROW;
					end
				end
				ST_FETCH_ROW: begin
					if (!o_mem_rreq) begin
						o_mem_rreq <= 1'b1;
						o_mem_addr <= mat_base + mem_addr_t'(row);
					end else if (i_mem_rrdy) begin
						o_mem_rreq <= 1'b0;
						col        <= (row == '0) ? idx_t'(1) : '0;
						state      <= ST_ISSUE;
					end
				end
				ST_ISSUE: begin
					o_row       <= row;
					o_col       <= col;
					o_last_iter <= last_iter;
					if (col == row) begin
						// diagonal slot carries the reciprocal
						o_op   <= OP_SOLVE;
						o_coef <= row_buf[row*COEF_W +: COEF_W];
						o_rhs  <= b_buf[row*COEF_W +: COEF_W];
						state  <= ST_WAIT_X;
					end else begin
						o_op   <= OP_MAC;
						o_coef <= row_buf[col*COEF_W +: COEF_W];
						col    <= col_nxt;
					end
				end
				ST_WAIT_X: begin
					if (i_x_upd) begin
						row <= row + 1'b1;
						if (!last_row) begin
							state <= ST_FETCH_ROW;
						end else if (!last_iter) begin
							iter  <= iter + 1'b1;
							state <= ST_FETCH_ROW;
						end else if (!last_mat) begin
							iter  <= '0;
							mat   <= mat + 1'b1;
							state <= ST_FETCH_B;
						end else begin
							iter  <= '0;
							state <= ST_DONE;
						end
					end
				end
				ST_DONE: begin
					if (!i_module_en) begin
						state <= ST_IDLE;
					end
				end
				default: begin
					state <= ST_IDLE;
				end
			endcase
		end
	end

	// b row kept for the whole matrix
	always_ff @(posedge i_clk) begin
		if (o_mem_rreq && i_mem_rrdy) begin
			if (state == ST_FETCH_B) begin
				b_buf <= i_mem_dout;
			end else begin
				row_buf <= i_mem_dout;
			end
		end
	end

	a_addr_hold: assert property (@(posedge i_clk) disable iff (i_reset)
		(o_mem_rreq && !i_mem_rrdy) |=> $stable(o_mem_addr));

endmodule

`default_nettype wire

/* src/gsim_execute.sv */
`default_nettype none

module gsim_execute (
	input  logic               i_clk,
	input  logic               i_reset,
	input  gsim_pkg::gsim_op_e i_op,
	input  gsim_pkg::idx_t     i_row,
	input  gsim_pkg::idx_t     i_col,
	input  gsim_pkg::coef_t    i_coef,
	input  gsim_pkg::coef_t    i_rhs,
	input  logic               i_last_iter,
	output logic               o_x_upd,
	output gsim_pkg::idx_t     o_x_row,
	output gsim_pkg::x_t       o_x_val,
	output logic               o_x_last
);
	import gsim_pkg::*;

	x_t    x_reg [N_DIM];
	logic  new_mat;
	logic  clr_x;
	x_t    x_rd;
	acc_t  mac_prod;

	logic  s1_mac;
	logic  s1_solve;
	logic  s1_last;
	acc_t  s1_prod;
	coef_t s1_recip;
	coef_t s1_rhs;
	idx_t  s1_row;
	acc_t  acc;

	logic  s2_solve;
	logic  s2_last;
	acc_t  s2_diff;
	coef_t s2_recip;
	idx_t  s2_row;

	logic signed [ACC_W+COEF_W:0] scaled;

	// first MAC of a new matrix is always row 0, column 1
	assign clr_x = new_mat && (i_op == OP_MAC) && (i_row == '0) && (i_col == idx_t'(1));
	assign x_rd  = clr_x ? '0 : x_reg[i_col];

	assign mac_prod = i_coef * x_rd;
	// reciprocal is unsigned Q0.16
	assign scaled   = s2_diff * $signed({1'b0, s2_recip});

	always_ff @(posedge i_clk or posedge i_reset) begin
		if (i_reset) begin
			new_mat <= 1'b1;
		end else if (clr_x) begin
			new_mat <= 1'b0;
		end else if ((i_op == OP_SOLVE) && i_last_iter && (i_row == idx_t'(N_DIM - 1))) begin
			new_mat <= 1'b1;
		end
	end

	always_ff @(posedge i_clk) begin
		if (clr_x) begin
			for (int k = 0; k < N_DIM; k++) begin
				x_reg[k] <= '0;
			end
		end else if (s2_solve) begin
			x_reg[s2_row] <= scaled[FRAC_BITS +: X_W];
		end
	end

	always_ff @(posedge i_clk or posedge i_reset) begin
		if (i_reset) begin
			s1_mac   <= 1'b0;
			s1_solve <= 1'b0;
			s2_solve <= 1'b0;
			o_x_upd  <= 1'b0;
			acc      <= '0;
		end else begin
			s1_mac   <= (i_op == OP_MAC);
			s1_solve <= (i_op == OP_SOLVE);
			s2_solve <= s1_solve;
			o_x_upd  <= s2_solve;
			// restart for the next row once the sum is taken
			if (s1_solve) begin
				acc <= '0;
			end else if (s1_mac) begin
				acc <= acc + s1_prod;
			end
		end
	end

	always_ff @(posedge i_clk) begin
		s1_prod  <= mac_prod;
		s1_recip <= i_coef;
		s1_rhs   <= i_rhs;
		s1_row   <= i_row;
		s1_last  <= i_last_iter;

		s2_diff  <= (acc_t'(s1_rhs) <<< FRAC_BITS) - acc;
		s2_recip <= s1_recip;
		s2_row   <= s1_row;
		s2_last  <= s1_last;

		o_x_row  <= s2_row;
		o_x_val  <= scaled[FRAC_BITS +: X_W];
		o_x_last <= s2_last;
	end

	a_no_diag_mac: assert property (@(posedge i_clk) disable iff (i_reset)
		(i_op == OP_MAC) |-> (i_col != i_row));

endmodule

`default_nettype wire

/* src/gsim_pkg.sv */
`default_nettype none

package gsim_pkg;

	localparam int N_DIM        = 16;
	localparam int ITER_COUNT   = 16;
	localparam int ROWS_PER_MAT = N_DIM + 1;

	localparam int MEM_AW    = 10;
	localparam int MEM_DW    = 256;
	localparam int COEF_W    = 16;
	localparam int X_W       = 32;
	localparam int ACC_W     = 48;
	localparam int FRAC_BITS = 16;
	localparam int IDX_W     = $clog2(N_DIM);
	localparam int ITER_W    = $clog2(ITER_COUNT);
	localparam int MAT_W     = 5;
	localparam int SOL_AW    = 9;

	typedef logic [MEM_AW-1:0]        mem_addr_t;
	typedef logic [MEM_DW-1:0]        mem_word_t;
	typedef logic signed [COEF_W-1:0] coef_t;
	// Q16.16
	typedef logic signed [X_W-1:0]    x_t;
	typedef logic signed [ACC_W-1:0]  acc_t;
	typedef logic [IDX_W-1:0]         idx_t;
	typedef logic [ITER_W-1:0]        iter_t;
	typedef logic [MAT_W-1:0]         mat_cnt_t;
	typedef logic [SOL_AW-1:0]        sol_addr_t;

	typedef enum logic [1:0] {
		OP_NOP   = 2'd0,
		OP_MAC   = 2'd1,
		OP_SOLVE = 2'd2
	} gsim_op_e;

	typedef enum logic [2:0] {
		ST_IDLE      = 3'd0,
		ST_FETCH_B   = 3'd1,
		ST_FETCH_ROW = 3'd2,
		ST_ISSUE     = 3'd3,
		ST_WAIT_X    = 3'd4,
		ST_DONE      = 3'd5
	} gsim_state_e;

endpackage

`default_nettype wire

/* src/gsim_result.sv */
`default_nettype none

module gsim_result (
	input  logic                i_clk,
	input  logic                i_reset,
	input  logic                i_x_upd,
	input  gsim_pkg::idx_t      i_x_row,
	input  gsim_pkg::x_t        i_x_val,
	input  logic                i_x_last,
	output logic                o_x_wen,
	output gsim_pkg::sol_addr_t o_x_addr,
	output gsim_pkg::x_t        o_x_data
);
	import gsim_pkg::*;

	logic fin_upd;
	idx_t prev_row;

	assign fin_upd = i_x_upd && i_x_last;

	always_ff @(posedge i_clk or posedge i_reset) begin
		if (i_reset) begin
			o_x_wen  <= 1'b0;
			o_x_addr <= '0;
			prev_row <= idx_t'(N_DIM - 1);
		end else begin
			o_x_wen <= fin_upd;
			// address only moves after a write
			if (o_x_wen) begin
				o_x_addr <= o_x_addr + 1'b1;
			end
			if (fin_upd) begin
				prev_row <= i_x_row;
			end
		end
	end

	always_ff @(posedge i_clk) begin
		if (fin_upd) begin
			o_x_data <= i_x_val;
		end
	end

	a_row_order: assert property (@(posedge i_clk) disable iff (i_reset)
		fin_upd |-> (i_x_row == idx_t'(prev_row + 1'b1)));

endmodule

`default_nettype wire

/* src/gsim_top.sv */
`default_nettype none

module gsim_top (
	input  logic                i_clk,
	input  logic                i_reset,
	input  logic                i_module_en,
	input  gsim_pkg::mat_cnt_t  i_matrix_num,
	output logic                o_proc_done,
	output logic                o_mem_rreq,
	output gsim_pkg::mem_addr_t o_mem_addr,
	input  logic                i_mem_rrdy,
	input  gsim_pkg::mem_word_t i_mem_dout,
	output logic                o_x_wen,
	output gsim_pkg::sol_addr_t o_x_addr,
	output gsim_pkg::x_t        o_x_data
);
	import gsim_pkg::*;

	gsim_op_e op;
	idx_t     op_row;
	idx_t     op_col;
	coef_t    op_coef;
	coef_t    op_rhs;
	logic     op_last_iter;

	logic     x_upd;
	idx_t     x_row;
	x_t       x_val;
	logic     x_last;

	gsim_decode u_decode (
		.i_clk        (i_clk),
		.i_reset      (i_reset),
		.i_module_en  (i_module_en),
		.i_matrix_num (i_matrix_num),
		.o_proc_done  (o_proc_done),
		.o_mem_rreq   (o_mem_rreq),
		.o_mem_addr   (o_mem_addr),
		.i_mem_rrdy   (i_mem_rrdy),
		.i_mem_dout   (i_mem_dout),
		.o_op         (op),
		.o_row        (op_row),
		.o_col        (op_col),
		.o_coef       (op_coef),
		.o_rhs        (op_rhs),
		.o_last_iter  (op_last_iter),
		.i_x_upd      (x_upd)
	);

	gsim_execute u_execute (
		.i_clk       (i_clk),
		.i_reset     (i_reset),
		.i_op        (op),
		.i_row       (op_row),
		.i_col       (op_col),
		.i_coef      (op_coef),
		.i_rhs       (op_rhs),
		.i_last_iter (op_last_iter),
		.o_x_upd     (x_upd),
		.o_x_row     (x_row),
		.o_x_val     (x_val),
		.o_x_last    (x_last)
	);

	gsim_result u_result (
		.i_clk    (i_clk),
		.i_reset  (i_reset),
		.i_x_upd  (x_upd),
		.i_x_row  (x_row),
		.i_x_val  (x_val),
		.i_x_last (x_last),
		.o_x_wen  (o_x_wen),
		.o_x_addr (o_x_addr),
		.o_x_data (o_x_data)
	);

endmodule

`default_nettype wire

/* tb.f */
src/gsim_pkg.sv
src/gsim_decode.sv
src/gsim_execute.sv
src/gsim_result.sv
src/gsim_top.sv
tests/gsim_mem_model.sv
tests/tb_gsim.sv

/* tests/gsim_mem_model.sv */
`default_nettype none

module gsim_mem_model (
	input  logic                i_clk,
	input  logic                i_reset,
	input  logic                i_rreq,
	input  gsim_pkg::mem_addr_t i_addr,
	input  logic [2:0]          i_delay,
	output logic                o_rrdy,
	output gsim_pkg::mem_word_t o_dout
);
	import gsim_pkg::*;

	mem_word_t  mem [2**MEM_AW];
	logic       busy;
	logic [2:0] wait_cnt;
	logic       hit;

	// data goes out with the pulse after the last wait cycle
	assign hit = busy && (wait_cnt <= 3'd1);

	always_ff @(posedge i_clk or posedge i_reset) begin
		if (i_reset) begin
			o_rrdy   <= 1'b0;
			busy     <= 1'b0;
			wait_cnt <= '0;
		end else begin
			o_rrdy <= 1'b0;
			if (hit) begin
				o_rrdy <= 1'b1;
				busy   <= 1'b0;
			end else if (busy) begin
				wait_cnt <= wait_cnt - 1'b1;
			end else if (i_rreq && !o_rrdy) begin
				// request still high in the pulse cycle is the old one
				busy     <= 1'b1;
				wait_cnt <= i_delay;
			end
		end
	end

	always_ff @(posedge i_clk) begin
		if (hit) begin
			o_dout <= mem[i_addr];
		end
	end

endmodule

`default_nettype wire

/* tests/tb_gsim.sv */
`default_nettype none

module tb_gsim;
	import gsim_pkg::*;

	localparam int SEED = 32'h42f3_b481;

	logic       clk;
	logic       reset;
	logic       module_en;
	mat_cnt_t   matrix_num;
	logic       proc_done;
	logic       mem_rreq;
	mem_addr_t  mem_addr;
	logic       mem_rrdy;
	mem_word_t  mem_dout;
	logic       x_wen;
	sol_addr_t  x_addr;
	x_t         x_data;
	logic       rand_delay;
	logic [2:0] mem_delay;

	// per matrix copies of what went into memory
	int        a_m [32][N_DIM][N_DIM];
	int        b_m [32][N_DIM];
	int        r_m [32][N_DIM];
	x_t        exp_q [$];
	mem_addr_t fetch_q [$];
	sol_addr_t exp_addr;
	int        writes_seen;
	int        writes_due;

	gsim_top DUT (
		.i_clk        (clk),
		.i_reset      (reset),
		.i_module_en  (module_en),
		.i_matrix_num (matrix_num),
		.o_proc_done  (proc_done),
		.o_mem_rreq   (mem_rreq),
		.o_mem_addr   (mem_addr),
		.i_mem_rrdy   (mem_rrdy),
		.i_mem_dout   (mem_dout),
		.o_x_wen      (x_wen),
		.o_x_addr     (x_addr),
		.o_x_data     (x_data)
	);

	gsim_mem_model u_mem (
		.i_clk   (clk),
		.i_reset (reset),
		.i_rreq  (mem_rreq),
		.i_addr  (mem_addr),
		.i_delay (mem_delay),
		.o_rrdy  (mem_rrdy),
		.o_dout  (mem_dout)
	);

	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	always @(posedge clk) begin
		mem_delay <= rand_delay ? 3'($urandom_range(6, 1)) : 3'd1;
	end

	task automatic end_with_failure();
		$display("Simulation failed");
		$fatal(1, "stopped at first error");
	endtask

	task automatic report(input string why);
		$display("%0t: %s", $time, why);
		end_with_failure();
	endtask

	task automatic compare_x(input string name, input x_t got, input x_t exp);
		if (got !== exp) begin
			$display("** Error at %0t: %s = %0d, expected %0d", $time, name, got, exp);
			end_with_failure();
		end
	endtask

	task automatic compare_addr(input string name, input sol_addr_t got, input sol_addr_t exp);
		if (got !== exp) begin
			$display("** Error at %0t: %s = %0d, expected %0d", $time, name, got, exp);
			end_with_failure();
		end
	endtask

	task automatic compare_mem_addr(input string name, input mem_addr_t got,
			input mem_addr_t exp);
		if (got !== exp) begin
			$display("** Error at %0t: %s = %0d, expected %0d", $time, name, got, exp);
			end_with_failure();
		end
	endtask

	task automatic compare_bit(input string name, input logic got, input logic exp);
		if (got !== exp) begin
			$display("** Error at %0t: %s = %b, expected %b", $time, name, got, exp);
			end_with_failure();
		end
	endtask

	// diagonal dominant by construction with 15 * bound below the diagonal
	task automatic fill_matrix(input int k);
		int        diag;
		int        bound;
		mem_word_t row;
		mem_word_t rhs;
		rhs = '0;
		for (int i = 0; i < N_DIM; i++) begin
			diag  = $urandom_range(64, 16);
			bound = (diag - 1) / 15;
			row   = '0;
			for (int j = 0; j < N_DIM; j++) begin
				if (j == i) begin
					a_m[k][i][j]    = 0;
					r_m[k][i]       = 65536 / diag;
					row[j*16 +: 16] = 16'(r_m[k][i]);
				end else begin
					a_m[k][i][j]    = int'($urandom_range(2 * bound)) - bound;
					row[j*16 +: 16] = 16'(a_m[k][i][j]);
				end
			end
			u_mem.mem[ROWS_PER_MAT*k + i] = row;
			b_m[k][i]       = int'($urandom_range(2000)) - 1000;
			rhs[i*16 +: 16] = 16'(b_m[k][i]);
		end
		u_mem.mem[ROWS_PER_MAT*k + N_DIM] = rhs;
	endtask

	// b row first, then every row once per iteration
	task automatic queue_fetches(input int k);
		fetch_q.push_back(mem_addr_t'(ROWS_PER_MAT*k + N_DIM));
		for (int it = 0; it < ITER_COUNT; it++) begin
			for (int i = 0; i < N_DIM; i++) begin
				fetch_q.push_back(mem_addr_t'(ROWS_PER_MAT*k + i));
			end
		end
	endtask

	// Gauss-Seidel in Q16.16 with the last sweep queued as expected values
	function automatic void ref_solve(input int k);
		x_t     x [N_DIM];
		longint acc;
		longint diff;
		for (int n = 0; n < N_DIM; n++) begin
			x[n] = '0;
		end
		for (int it = 0; it < ITER_COUNT; it++) begin
			for (int i = 0; i < N_DIM; i++) begin
				acc = 0;
				for (int j = 0; j < N_DIM; j++) begin
					if (j != i) begin
						acc += longint'(a_m[k][i][j]) * longint'(x[j]);
					end
				end
				diff = (longint'(b_m[k][i]) <<< 16) - acc;
				x[i] = x_t'((diff * longint'(r_m[k][i])) >>> 16);
				if (it == ITER_COUNT - 1) begin
					exp_q.push_back(x[i]);
				end
			end
		end
	endfunction

	task automatic run_job(input int nmat);
		int cyc;
		@(negedge clk);
		for (int k = 0; k < nmat; k++) begin
			fill_matrix(k);
			ref_solve(k);
			queue_fetches(k);
		end
		writes_due += nmat * N_DIM;
		@(posedge clk);
		matrix_num <= mat_cnt_t'(nmat);
		module_en  <= 1'b1;
		cyc = 0;
		while (!proc_done && cyc < nmat * 20000) begin
			@(negedge clk);
			cyc++;
		end
		if (!proc_done) report("timeout waiting for o_proc_done");
		if (exp_q.size() != 0) report("o_proc_done rose before all solution writes");
		if (fetch_q.size() != 0) report("o_proc_done rose before all memory rows were read");
		repeat (6) begin
			@(negedge clk);
			compare_bit("o_proc_done", proc_done, 1'b1);
		end
		@(posedge clk);
		module_en <= 1'b0;
		cyc = 0;
		while (proc_done && cyc < 20) begin
			@(negedge clk);
			cyc++;
		end
		if (proc_done) report("o_proc_done stayed high after i_module_en dropped");
	endtask

	// solution writes checked mid cycle
	always @(negedge clk) begin
		if (x_wen === 1'b1) begin
			if (exp_q.size() == 0) report("solution write with no expected value pending");
			compare_addr("o_x_addr", x_addr, exp_addr);
			compare_x("o_x_data", x_data, exp_q.pop_front());
			exp_addr = exp_addr + 1'b1;
			writes_seen++;
		end
	end

	// row fetch order
	always @(negedge clk) begin
		if (mem_rreq === 1'b1 && mem_rrdy === 1'b1) begin
			if (fetch_q.size() == 0) report("memory read with no row fetch expected");
			compare_mem_addr("o_mem_addr", mem_addr, fetch_q.pop_front());
		end
	end

	initial begin
		void'($urandom(SEED));
		reset       = 1'b1;
		module_en   = 1'b0;
		matrix_num  = '0;
		rand_delay  = 1'b0;
		mem_delay   = 3'd1;
		exp_addr    = '0;
		writes_seen = 0;
		writes_due  = 0;

		repeat (8) begin
			@(negedge clk);
			compare_bit("o_mem_rreq", mem_rreq, 1'b0);
			compare_bit("o_x_wen", x_wen, 1'b0);
			compare_bit("o_proc_done", proc_done, 1'b0);
			@(posedge clk);
		end
		reset <= 1'b0;
		repeat (4) begin
			@(negedge clk);
			compare_bit("o_mem_rreq", mem_rreq, 1'b0);
			compare_bit("o_x_wen", x_wen, 1'b0);
			compare_bit("o_proc_done", proc_done, 1'b0);
		end

		// five matrices fill addresses 0 to 79
		run_job(5);
		// single matrix with addresses carrying on from 80
		run_job(1);
		@(posedge clk);
		rand_delay <= 1'b1;
		run_job(3);

		@(negedge clk);
		if (writes_seen == writes_due && exp_q.size() == 0) begin
			$display("Simulation passed");
			$finish;
		end else begin
			report("number of solution writes differs from the expected count");
		end
	end

endmodule

`default_nettype wire
